// File: rx_pkg.sv
/*
  rx link shared definitions
  word format, framer and checker state encodings and the test-mode constants
  used across the receive path
*/

package rx_pkg;

  // one payload word as it travels from framer through the fifo to the consumer
  typedef struct packed {
    logic [15:0] data;  // payload value that counts up in test mode
    logic        last;  // high on the final payload word of a frame
  } rx_word_t;

  // frame hunter states
  // value 3 is not a state of this link
  typedef enum logic [2:0] {
    SYNC_IDLE   = 3'd0,  // hunting for the first header word
    SYNC_START  = 3'd1,  // first header word seen
    SYNC_RX_1_2 = 3'd2,  // header complete one cycle before payload
    SYNC_RX     = 3'd4,  // taking payload words
    SYNC_FINISH = 3'd5   // waiting for the last payload word
  } sync_state_t;

  // sequence checker states
  typedef enum logic {
    TMC_IDLE = 1'b0,  // disarmed until a fresh header
    TMC_GO   = 1'b1   // armed so every write and pop is checked
  } tmc_state_t;

  localparam logic [15:0] SYNC_WORD = 16'h7F7F;  // both header words carry this value

  // test-mode payload counts 1 .. SEQ_MAX and then wraps back to 1
  localparam logic [15:0] SEQ_MAX = 16'd252;

endpackage

// File: rx_frame_sync.sv
/*
  rx frame sync
  hunts for the two-word sync header, tracks the frame state and hands each
  payload word to the receive fifo in the cycle it is accepted
*/

`timescale 1ns/1ps

module rx_frame_sync
  import rx_pkg::*;
#(
  parameter int PAYLOAD_LEN = 16  // payload words per frame
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] in_data,     // incoming link word
  input  logic        in_valid,    // in_data holds a word
  output logic        in_ready,    // word is taken when valid and ready are both high
  input  logic        full,        // fifo cannot take another word
  output rx_word_t    wr_word,     // payload word toward the fifo
  output logic        wr_en,       // write strobe toward the fifo
  output sync_state_t sync_state   // current frame state that the checker also watches
);

  localparam int CNT_W = $clog2(PAYLOAD_LEN + 1);

  sync_state_t      state_next;
  logic [CNT_W-1:0] word_cnt;  // payload words written so far in this frame
  logic             live;      // goes high one cycle after reset is released
  logic             payload;   // state in which accepted words are payload
  logic             take;      // a word is accepted this cycle

  assign payload = (sync_state == SYNC_RX) || (sync_state == SYNC_FINISH);

  // header words are always taken while payload waits for fifo room
  // the single cycle in SYNC_RX_1_2 lets the checker arm before the first write
  assign in_ready = live && (sync_state != SYNC_RX_1_2) && !(payload && full);

  assign take  = in_valid && in_ready;
  assign wr_en = take && payload;  // words outside a frame are simply dropped

  assign wr_word = '{data: in_data, last: (sync_state == SYNC_FINISH)};  // last word flagged

  always_comb
  begin
    state_next = sync_state;
    case (sync_state)
      SYNC_IDLE:
        if (take && (in_data == SYNC_WORD))
          state_next = SYNC_START;  // possible first header word
      SYNC_START:
        if (take)
          state_next = (in_data == SYNC_WORD) ? SYNC_RX_1_2 : SYNC_IDLE;  // broken header restarts the hunt
      SYNC_RX_1_2:
        state_next = (PAYLOAD_LEN == 1) ? SYNC_FINISH : SYNC_RX;  // a one-word frame goes straight to finish
      SYNC_RX:
        if (take && (word_cnt == CNT_W'(PAYLOAD_LEN - 2)))
          state_next = SYNC_FINISH;  // next accepted word closes the frame
      SYNC_FINISH:
        if (take)
          state_next = SYNC_IDLE;  // the frame is done and the hunt for the next header starts
      default:
        state_next = SYNC_IDLE;  // unused encodings fall back to hunting
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sync_state <= SYNC_IDLE;
      word_cnt   <= '0;
      live       <= 1'b0;
    end
    else
    begin
      sync_state <= state_next;
      live       <= 1'b1;
      if (sync_state == SYNC_RX_1_2)
        word_cnt <= '0;  // fresh count for each frame
      else if (wr_en)
        word_cnt <= word_cnt + 1'b1;
    end
  end

  // the fifo write side has no guard of its own, so a write into a full fifo would corrupt it
  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> !full);

endmodule

// File: rx_fifo.sv
/*
  rx fifo
  synchronous first-word-fall-through buffer between framer and consumer
  head word is presented continuously and leaves on a valid/ready pop
*/

`timescale 1ns/1ps

module rx_fifo
  import rx_pkg::*;
#(
  parameter int FIFO_DEPTH = 32  // must be a power of two
) (
  input  logic                        clk,
  input  logic                        rst,
  input  rx_word_t                    wr_word,    // word to store
  input  logic                        wr_en,      // store wr_word this cycle
  output logic                        full,       // no room for another word
  output rx_word_t                    out_word,   // head of the queue
  output logic                        out_valid,  // out_word holds a stored word
  input  logic                        out_ready,  // consumer takes the head word
  output logic [$clog2(FIFO_DEPTH):0] used        // words currently stored
);

  localparam int AW = $clog2(FIFO_DEPTH);

  rx_word_t      mem [FIFO_DEPTH];  // storage, contents are don't-care until written
  logic [AW-1:0] wr_ptr;            // next slot to write
  logic [AW-1:0] rd_ptr;            // slot holding the head word
  logic          pop;               // head word leaves this cycle

  assign full      = (used == (AW + 1)'(FIFO_DEPTH));
  assign out_valid = (used != '0);
  assign out_word  = mem[rd_ptr];  // head read straight from storage, no read latency
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_word;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;  // wraps on its own since depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;  // both or neither leaves the count alone
      endcase
    end
  end

  a_used_in_range: assert property (@(posedge clk) disable iff (rst)
    used <= (AW + 1)'(FIFO_DEPTH));

  // an offered word that is not taken stays put until the consumer takes it
  a_head_holds: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_word)));

endmodule

// File: seq_checker.sv
/*
  test-mode sequence checker
  watches writes into and pops out of the rx fifo and flags any word that breaks
  the 1 .. SEQ_MAX counting sequence, re-arming on the next complete header
*/

`timescale 1ns/1ps

module seq_checker
  import rx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  sync_state_t sync_state,  // framer state that arms and disarms the checker
  input  logic        wr_en,       // fifo write strobe
  input  rx_word_t    wr_word,     // word being written
  input  logic        out_valid,   // fifo has a head word
  input  logic        out_ready,   // consumer takes it
  input  rx_word_t    out_word,    // head word
  output logic        seq_err      // one-cycle pulse on a bad write or pop
);

  tmc_state_t  tmc_state;
  tmc_state_t  tmc_next;
  sync_state_t sync_prev;   // framer state one cycle ago
  logic [15:0] exp_wr;      // value the next write must carry
  logic [15:0] last_rd;     // value of the most recent pop
  logic [15:0] exp_rd;      // value that continues the read sequence
  logic        pop;
  logic        wr_bad;
  logic        rd_bad;
  logic        err_hit;     // a checked write or pop failed this cycle
  logic        lost_frame;  // the header hunt gave up and the link lost framing

  // next value in the sequence where anything at or above the top goes back to 1
  function automatic logic [15:0] seq_step(input logic [15:0] v);
    seq_step = (v >= SEQ_MAX) ? 16'd1 : v + 16'd1;
  endfunction

  assign exp_rd = seq_step(last_rd);
  assign pop    = out_valid && out_ready;

  assign wr_bad = wr_en && (wr_word.data != exp_wr);
  // the writer starts again at 1 after a resync, so 1 is always an allowed pop
  assign rd_bad = pop && (out_word.data != exp_rd) && (out_word.data != 16'd1);

  assign err_hit    = (tmc_state == TMC_GO) && (wr_bad || rd_bad);
  assign lost_frame = (sync_state == SYNC_IDLE) && (sync_prev == SYNC_START);

  always_comb
  begin
    tmc_next = tmc_state;
    case (tmc_state)
      TMC_IDLE:
        if (sync_state == SYNC_RX_1_2)
          tmc_next = TMC_GO;  // a full header was seen and payload follows next cycle
      TMC_GO:
        if (err_hit || lost_frame)
          tmc_next = TMC_IDLE;  // wait for a fresh header before checking again
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tmc_state <= TMC_IDLE;
      sync_prev <= SYNC_IDLE;
      exp_wr    <= 16'd1;
      last_rd   <= 16'd0;  // makes 1 the expected first pop
      seq_err   <= 1'b0;
    end
    else
    begin
      tmc_state <= tmc_next;
      sync_prev <= sync_state;
      seq_err   <= err_hit;  // state leaves TMC_GO together with this, so it is one pulse
      if (tmc_state != TMC_GO)
        exp_wr <= 16'd1;  // writer restarts its count after every resync
      else if (wr_en)
        exp_wr <= seq_step(exp_wr);
      if (pop)
        last_rd <= out_word.data;  // track pops even while disarmed
    end
  end

endmodule

// File: period_monitor.sv
/*
  strobe period monitor
  counts cycles between rising edges of a strobe and raises late while the
  gap has grown past LIMIT
*/

`timescale 1ns/1ps

module period_monitor #(
  parameter int LIMIT = 500  // longest allowed gap between rising edges in cycles
) (
  input  logic clk,
  input  logic rst,
  input  logic strobe,  // periodic strobe under watch
  output logic late     // gap since the last edge is over LIMIT
);

  localparam int CNT_W = $clog2(LIMIT + 2);  // counter can always reach LIMIT + 1

  logic [CNT_W-1:0] gap_cnt;   // cycles since the last rising edge that saturate at all ones
  logic             strobe_d;  // strobe one cycle ago
  logic             rise;

  assign rise = strobe && !strobe_d;
  assign late = (gap_cnt > CNT_W'(LIMIT));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      strobe_d <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      strobe_d <= strobe;
      if (rise)
        gap_cnt <= '0;  // an edge starts a new period
      else if (gap_cnt != '1)
        gap_cnt <= gap_cnt + 1'b1;  // stops at all ones so late holds
    end
  end

endmodule

// File: rx_test_top.sv
/*
  rx test-mode top level
  frame sync, receive fifo, sequence checker and two strobe monitors, with
  every error source merged onto tmc_err
*/

`timescale 1ns/1ps

module rx_test_top
  import rx_pkg::*;
#(
  parameter int PAYLOAD_LEN = 16,    // payload words per frame
  parameter int FIFO_DEPTH  = 32,    // power of two
  parameter int LR_LIMIT    = 500,   // longest lr_sync period in cycles
  parameter int XRDY_LIMIT  = 1000   // longest xrdy period in cycles
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [15:0]                 in_data,
  input  logic                        in_valid,
  output logic                        in_ready,
  output rx_word_t                    out_word,
  output logic                        out_valid,
  input  logic                        out_ready,
  input  logic                        lr_sync,     // audio left/right sync strobe
  input  logic                        xrdy,        // codec-ready strobe
  output logic                        tmc_err,     // any test-mode failure
  output sync_state_t                 sync_state,
  output logic [$clog2(FIFO_DEPTH):0] used
);

  rx_word_t wr_word;
  logic     wr_en;
  logic     full;
  logic     seq_err;
  logic     lr_late;
  logic     xrdy_late;

  assign tmc_err = seq_err || lr_late || xrdy_late;

  rx_frame_sync #(
    .PAYLOAD_LEN (PAYLOAD_LEN)
  ) rx_frame_sync_inst (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .full       (full),
    .wr_word    (wr_word),
    .wr_en      (wr_en),
    .sync_state (sync_state)
  );

  rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) rx_fifo_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_word   (wr_word),
    .wr_en     (wr_en),
    .full      (full),
    .out_word  (out_word),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .used      (used)
  );

  seq_checker seq_checker_inst (
    .clk        (clk),
    .rst        (rst),
    .sync_state (sync_state),
    .wr_en      (wr_en),
    .wr_word    (wr_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_word   (out_word),
    .seq_err    (seq_err)
  );

  period_monitor #(.LIMIT (LR_LIMIT)) lr_mon (
    .clk    (clk),
    .rst    (rst),
    .strobe (lr_sync),
    .late   (lr_late)
  );

  period_monitor #(.LIMIT (XRDY_LIMIT)) xrdy_mon (
    .clk    (clk),
    .rst    (rst),
    .strobe (xrdy),
    .late   (xrdy_late)
  );

endmodule

// File: tb_clkgen.sv
/*
  testbench clock and reset source
  8 ns free-running clock and a synchronous reset held for five rising edges
*/

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int HALF_NS    = 4,  // half of the clock period
  parameter int RST_CYCLES = 5   // rising edges that see reset high
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // dropped on a falling edge like every other input
  end

endmodule

// File: rx_test_tb.sv
/*
  rx test-mode testbench
  random framed traffic against a queue model of the payload, back-pressure,
  a corrupted payload word, a broken header and strobe watchdog checks
*/

`timescale 1ns/1ps

module rx_test_tb
  import rx_pkg::*;
();

  localparam int PAYLOAD_LEN = 16;
  localparam int FIFO_DEPTH  = 32;
  localparam int LR_LIMIT    = 500;
  localparam int XRDY_LIMIT  = 1000;
  localparam int LR_PER      = 100;   // normal strobe periods well inside the limits
  localparam int XRDY_PER    = 300;
  localparam int WAIT_MAX    = 3000;  // cycle budget for one wait

  logic                        clk;
  logic                        rst;
  logic [15:0]                 in_data;
  logic                        in_valid;
  logic                        in_ready;
  rx_word_t                    out_word;
  logic                        out_valid;
  logic                        out_ready;
  logic                        lr_sync;
  logic                        xrdy;
  logic                        tmc_err;
  sync_state_t                 sync_state;
  logic [$clog2(FIFO_DEPTH):0] used;

  rx_word_t    model_q[$];  // payload words sent and not yet popped
  logic [15:0] seq_val;     // next value of the counting sequence
  string       test_name;
  int          mism_cnt;
  int          fail_cnt;
  int          err_hits;    // cycles seen with tmc_err high
  bit          cons_hold;   // consumer keeps out_ready low
  bit          hold_lr;     // lr_sync strobe withheld
  bit          hold_xrdy;   // xrdy strobe withheld
  bit          err_quiet;   // tmc_err must stay low

  tb_clkgen clkgen_inst (
    .clk (clk),
    .rst (rst)
  );

  rx_test_top #(
    .PAYLOAD_LEN (PAYLOAD_LEN),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .LR_LIMIT    (LR_LIMIT),
    .XRDY_LIMIT  (XRDY_LIMIT)
  ) rx_test_top_inst (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_word   (out_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .lr_sync    (lr_sync),
    .xrdy       (xrdy),
    .tmc_err    (tmc_err),
    .sync_state (sync_state),
    .used       (used)
  );

  // test-mode payload runs 1 .. SEQ_MAX and then starts again at 1
  function automatic logic [15:0] next_val(input logic [15:0] v);
    if (v == SEQ_MAX)
      return 16'd1;
    return v + 16'd1;
  endfunction

  task automatic check_val(input string what, input int exp, input int act);
    assert (exp == act) else
    begin
      mism_cnt++;
      $display("mismatch %s %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  // one word offered after a random gap and held until the framer takes it
  task automatic send_word(input logic [15:0] d);
    int gap;
    int waited;
    gap    = $urandom % 3;
    waited = 0;
    repeat (gap)
    begin
      @(negedge clk);
      in_valid = 1'b0;
    end
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = d;
    while (!in_ready && waited < WAIT_MAX)
    begin
      @(negedge clk);
      waited++;
    end
    assert (in_ready) else
    begin
      fail_cnt++;
      $display("timeout in %s, word %h was never accepted", test_name, d);
    end
  endtask

  // header plus one frame of payload with an optional word knocked off the sequence
  task automatic send_frame(input bit corrupt);
    int          bad_idx;
    int          i;
    logic [15:0] d;
    rx_word_t    w;
    bad_idx = $urandom % PAYLOAD_LEN;
    send_word(SYNC_WORD);
    send_word(SYNC_WORD);
    for (i = 0; i < PAYLOAD_LEN; i++)
    begin
      d = (corrupt && i == bad_idx) ? (seq_val ^ 16'h0100) : seq_val;  // never a sequence value
      send_word(d);
      w.data = d;
      w.last = (i == PAYLOAD_LEN - 1);  // the PAYLOAD_LEN-th word closes the frame
      model_q.push_back(w);
      seq_val = next_val(seq_val);
    end
  endtask

  task automatic idle_input();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((model_q.size() != 0 || out_valid) && waited < WAIT_MAX)
    begin
      @(negedge clk);
      waited++;
    end
    assert (model_q.size() == 0 && !out_valid) else
    begin
      fail_cnt++;
      $display("timeout in %s, %0d words still outstanding", test_name, model_q.size());
    end
  endtask

  task automatic wait_tmc(input logic level, input int limit, output int waited);
    waited = 0;
    while (tmc_err !== level && waited < limit)
    begin
      @(negedge clk);
      waited++;
    end
    assert (tmc_err === level) else
    begin
      fail_cnt++;
      $display("timeout in %s, tmc_err never went to %0b", test_name, level);
    end
  endtask

  task automatic check_pop();
    rx_word_t exp_word;
    assert (model_q.size() != 0) else
    begin
      fail_cnt++;
      $display("error in %s, word %h popped with nothing sent", test_name, out_word.data);
    end
    if (model_q.size() != 0)
    begin
      exp_word = model_q.pop_front();
      check_val("pop", int'(exp_word), int'(out_word));  // data and last flag together
    end
  endtask

  // the consumer pops on the next rising edge when valid and ready are both high
  initial
  begin
    out_ready = 1'b0;
    forever
    begin
      @(negedge clk);
      out_ready = !rst && !cons_hold && ($urandom % 4 != 0);
      if (out_valid && out_ready)
        check_pop();
    end
  end

  // one-cycle strobes where a withheld strobe fires again right after release
  initial
  begin
    int lr_cnt;
    int xrdy_cnt;
    lr_sync  = 1'b0;
    xrdy     = 1'b0;
    lr_cnt   = 0;
    xrdy_cnt = 0;
    forever
    begin
      @(negedge clk);
      lr_sync  = !hold_lr && (lr_cnt == 0);
      lr_cnt   = hold_lr ? 0 : (lr_cnt + 1) % LR_PER;
      xrdy     = !hold_xrdy && (xrdy_cnt == 0);
      xrdy_cnt = hold_xrdy ? 0 : (xrdy_cnt + 1) % XRDY_PER;
    end
  end

  initial
  begin
    err_hits = 0;
    forever
    begin
      @(negedge clk);
      if (tmc_err)
        err_hits++;
      if (err_quiet)
        assert (!tmc_err) else
        begin
          fail_cnt++;
          $display("error in %s, tmc_err went high on good traffic", test_name);
        end
    end
  end

  initial
  begin
    #1_000_000;
    $display("simulation watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    int waited;
    int hits0;
    void'($urandom(32'h85a6_8090));
    in_data   = 16'h0000;
    in_valid  = 1'b0;
    cons_hold = 1'b0;
    hold_lr   = 1'b0;
    hold_xrdy = 1'b0;
    err_quiet = 1'b0;
    mism_cnt  = 0;
    fail_cnt  = 0;
    seq_val   = 16'd1;
    test_name = "reset";
    @(negedge clk);
    check_val("in_ready", 0, int'(in_ready));  // the framer takes nothing while reset is held
    check_val("tmc_err", 0, int'(tmc_err));
    waited    = 0;
    while (rst !== 1'b0 && waited < 20)
    begin
      @(negedge clk);
      waited++;
    end
    @(negedge clk);
    check_val("sync_state", int'(SYNC_IDLE), int'(sync_state));
    check_val("out_valid", 0, int'(out_valid));
    err_quiet = 1'b1;

    test_name = "clean_stream";
    repeat (20) send_frame(1'b0);  // 320 words wrap the sequence past SEQ_MAX
    idle_input();
    wait_drained();

    test_name = "payload_corruption";
    err_quiet = 1'b0;
    hits0     = err_hits;
    send_frame(1'b1);
    idle_input();
    waited = 0;
    while (err_hits == hits0 && waited < 50)
    begin
      @(negedge clk);
      waited++;
    end
    assert (err_hits != hits0) else
    begin
      fail_cnt++;
      $display("error in %s, tmc_err never flagged the bad word", test_name);
    end
    wait_drained();
    err_quiet = 1'b1;
    seq_val   = 16'd1;  // checker counts from 1 again once a header re-arms it
    repeat (2) send_frame(1'b0);
    idle_input();
    wait_drained();

    test_name = "bad_header";
    send_word(SYNC_WORD);
    send_word(16'h1234);
    idle_input();
    check_val("sync_state", int'(SYNC_IDLE), int'(sync_state));
    repeat (8) @(negedge clk);
    check_val("out_valid", 0, int'(out_valid));
    seq_val = 16'd1;  // the broken header disarms the checker as well

    test_name = "back_pressure";
    cons_hold = 1'b1;
    fork
      repeat (3) send_frame(1'b0);
      begin
        waited = 0;
        while ((in_ready || !(sync_state inside {SYNC_RX, SYNC_FINISH})) && waited < WAIT_MAX)
        begin
          @(negedge clk);
          waited++;
        end
        check_val("used", FIFO_DEPTH, int'(used));
        cons_hold = 1'b0;
      end
    join
    idle_input();
    wait_drained();

    test_name = "xrdy_watchdog";
    err_quiet = 1'b0;
    hold_xrdy = 1'b1;
    wait_tmc(1'b1, XRDY_LIMIT + XRDY_PER, waited);
    assert (waited >= XRDY_LIMIT - XRDY_PER) else
    begin
      fail_cnt++;
      $display("error in %s, tmc_err rose after only %0d cycles", test_name, waited);
    end
    @(posedge clk);
    hold_xrdy = 1'b0;
    wait_tmc(1'b0, 10, waited);

    test_name = "lr_watchdog";
    hold_lr = 1'b1;
    wait_tmc(1'b1, LR_LIMIT + LR_PER, waited);
    assert (waited >= LR_LIMIT - LR_PER) else
    begin
      fail_cnt++;
      $display("error in %s, tmc_err rose after only %0d cycles", test_name, waited);
    end
    @(posedge clk);
    hold_lr = 1'b0;
    wait_tmc(1'b0, 10, waited);
    err_quiet = 1'b1;
    repeat (2 * XRDY_PER) @(negedge clk);  // both strobes back on their normal periods

    $display("errors: %0d mismatch, %0d other", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: vlog.f
rx_pkg.sv
rx_frame_sync.sv
rx_fifo.sv
seq_checker.sv
period_monitor.sv
rx_test_top.sv
tb_clkgen.sv
rx_test_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = rx_test_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, the exit status follows the pass line
run: $(SIM)
	$(SIM) | awk '{ print } /^TB PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
